// ==== files.f ====
hw/ifu_pkg.sv
hw/ifu_fetch_buf.sv
hw/ifu_predecode.sv
hw/ifu_next_pc.sv
hw/ifu_out_stage.sv
hw/ifu.sv
testbench/ifu_assert.sv
testbench/ifu_tb.sv

// ==== Makefile ====
TOP = ifu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only hw/ifu_pkg.sv hw/ifu_fetch_buf.sv hw/ifu_predecode.sv \
		hw/ifu_next_pc.sv hw/ifu_out_stage.sv hw/ifu.sv --top-module ifu

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/ifu_tb.sv ====
/*
 * fetch unit testbench: clock, reset, memory model with a program image,
 * reference model of the fetch stream, output checker and watchdog
 */
`default_nettype none

module ifu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tests = 5;
  localparam int clk_period = 40;

  logic                clk;
  logic                rst_n;
  logic                redirect;
  logic [31:1]         redirect_pc;
  ifu_pkg::imem_req_t  imem;
  logic                imem_rvalid;
  logic [31:0]         imem_rdata;
  ifu_pkg::fetch_out_t out;
  logic                out_valid;

  logic [31:0] mem [64];
  integer      seed;
  int          checked;
  int          errors;
  int          test_errors;
  int          test_num;
  logic [31:1] walk_pc;  // where the expected stream continues
  ifu_pkg::fetch_out_t exp_q[$];

  ifu #(.reset_pc(31'd0)) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem        (imem),
    .imem_rvalid (imem_rvalid),
    .imem_rdata  (imem_rdata),
    .out         (out),
    .out_valid   (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // unused words read as ADDI x0 with an immediate folded from the address
  function automatic logic [31:0] fill_word(input logic [31:2] a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'b0, a[31:26]};
    return {imm, 20'h00013};
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:2] a);
    if (a < 30'd64) return mem[a[7:2]];
    return fill_word(a);
  endfunction

  function automatic logic [15:0] read_half(input logic [31:1] hp);
    logic [31:0] w;
    w = mem_word(hp[31:2]);
    return hp[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [15:0] enc_cj(input logic [2:0] f3, input logic [11:0] off);
    return {f3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
  endfunction

  task automatic put16(input logic [7:0] ba, input logic [15:0] val);
    if (ba[1]) mem[ba[7:2]][31:16] = val;
    else mem[ba[7:2]][15:0] = val;
  endtask

  task automatic put32(input logic [7:0] ba, input logic [31:0] val);
    put16(ba, val[15:0]);
    put16(ba + 8'd2, val[31:16]);
  endtask

  // expected item at pc and the pc that follows it
  function automatic ifu_pkg::fetch_out_t ref_step(input logic [31:1] pc,
                                                   output logic [31:1] npc);
    ifu_pkg::fetch_out_t r;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] w;
    logic [31:0] off;
    logic [31:0] nb;
    logic        comp;
    logic        jmp;
    lo = read_half(pc);
    hi = read_half(pc + 31'd1);
    w = {hi, lo};
    comp = lo[1:0] != 2'b11;
    r.instr = comp ? {16'h0000, lo} : w;
    r.pc = pc;
    r.compressed = comp;
    r.br_taken = 1'b0;
    r.illegal = lo == 16'h0000;
    r.br = comp ? (lo[1:0] == 2'b01 && lo[15:14] == 2'b11) : (w[6:0] == 7'b1100011);
    jmp = comp ? (lo[1:0] == 2'b01 && lo[14:13] == 2'b01) : (w[6:0] == 7'b1101111);
    off = comp ? {{20{lo[12]}}, lo[12], lo[8], lo[10:9], lo[6], lo[7], lo[2], lo[11],
                  lo[5:3], 1'b0}
               : {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    nb = {pc, 1'b0} + off;
    if (jmp) npc = nb[31:1];
    else npc = pc + (comp ? 31'd1 : 31'd2);
    return r;
  endfunction

  task automatic compare_out(input ifu_pkg::fetch_out_t got, input ifu_pkg::fetch_out_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: out got %h expected %h (pc %h)", $time, got, exp,
               {exp.pc, 1'b0});
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_req(input ifu_pkg::imem_req_t got, input ifu_pkg::imem_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: imem got %h expected %h", $time, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // memory model, one request in flight with 1 to 4 cycles of latency
  initial begin
    logic        take;
    logic [31:2] taddr;
    logic [31:2] raddr;
    int          countdown;
    imem_rvalid = 1'b0;
    imem_rdata = '0;
    countdown = 0;
    raddr = '0;
    forever begin
      @(negedge clk);
      take = imem.req;
      taddr = imem.addr;
      @(posedge clk);
      #2;
      imem_rvalid = 1'b0;
      if (take) begin
        countdown = 1 + int'($unsigned($random(seed)) % 4);
        raddr = taddr;
      end
      if (countdown != 0) begin
        countdown--;
        if (countdown == 0) begin
          imem_rvalid = 1'b1;
          imem_rdata = mem_word(raddr);
        end
      end
    end
  end

  initial begin
    ifu_pkg::fetch_out_t e;
    logic [31:1] nxt;
    walk_pc = '0;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid) begin
        if (exp_q.size() == 0) begin
          e = ref_step(walk_pc, nxt);
          walk_pc = nxt;
          exp_q.push_back(e);
        end
        e = exp_q.pop_front();
        compare_out(out, e);
        checked++;
      end
      if (redirect) begin  // the item shown in the redirect cycle still belongs to the old path
        walk_pc = redirect_pc;
        exp_q.delete();
      end
    end
  end

  task automatic finish_test(input int n, input string name);
    int target;
    target = checked + n;
    while (checked < target) @(posedge clk);
    test_num++;
    $display("test %0d %s: %0d items, %0d errors", test_num, name, n, test_errors);
    test_errors = 0;
  endtask

  // fires right after a request so that its response is still pending
  task automatic redirect_to(input logic [31:0] byte_addr);
    do @(negedge clk); while (imem.req !== 1'b1);
    @(posedge clk);
    #2;
    redirect = 1'b1;
    redirect_pc = byte_addr[31:1];
    @(posedge clk);
    #2;
    redirect = 1'b0;
  endtask

  initial begin
    #(num_tests * 200 * clk_period + 100 * clk_period);
    $display("timeout: the fetch unit stopped delivering instructions");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    ifu_pkg::imem_req_t first_req;
    seed = 27412;
    rst_n = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    checked = 0;
    errors = 0;
    test_errors = 0;
    test_num = 0;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(30'(i));
    put32(8'h00, 32'h00108093);                 // addi x1, x1, 1
    put16(8'h04, 16'h0085);                     // c.addi x1, 1
    put32(8'h06, 32'h00108093);                 // misaligned across two words
    put16(8'h0a, 16'hc001);                     // c.beqz
    put32(8'h0c, 32'h00209463);                 // bne x1, x2, +8
    put16(8'h10, 16'h0000);
    put16(8'h12, 16'h0085);
    put32(8'h14, enc_jal(5'd0, 21'd12));        // forward to 0x20
    put16(8'h20, enc_cj(3'b101, 12'd8));        // c.j to 0x28
    put16(8'h28, enc_cj(3'b001, 12'd22));       // c.jal to 0x3e
    put32(8'h2e, 32'h00108093);
    put16(8'h32, 16'he001);                     // c.bnez
    put16(8'h34, 16'h0085);
    put32(8'h36, enc_jal(5'd1, -21'sd50));      // back to 0x04
    put16(8'h3e, enc_cj(3'b101, -12'sd16));     // back to 0x2e
    first_req.req = 1'b1;
    first_req.addr = 30'd0;  // word of the reset pc
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // the first request is on the port in the cycle after the first edge out of reset
    repeat (2) @(negedge clk);
    compare_req(imem, first_req);
    finish_test(8, "sequential, misaligned, branches, illegal");
    finish_test(24, "direct jumps and loop");
    redirect_to(32'h20);
    finish_test(10, "redirect to 0x20");
    redirect_to(32'h06);
    finish_test(10, "redirect to 0x06");
    redirect_to(32'h2e);
    finish_test(10, "redirect to 0x2e");
    $display("%0d tests, %0d items checked, %0d errors", test_num, checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/ifu_assert.sv ====
/*
 * concurrent checks on the fetch buffer memory port and redirect behavior
 */
`default_nettype none

module ifu_assert (
  input logic               clk,
  input logic               rst_n,
  input ifu_pkg::imem_req_t imem,
  input logic               imem_rvalid,
  input logic               outstanding,
  input logic               redirect,
  input logic               window_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  logic pending;  // a request seen on the port still waits for its response

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pending <= 1'b0;
    else if (imem.req) pending <= 1'b1;
    else if (imem_rvalid) pending <= 1'b0;
  end

  // only one request may be in flight on the port
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    imem.req |-> !pending) else $error("second request while one is in flight");

  // the buffer has to hold off new requests for as long as one is in flight
  a_outstanding_held: assert property (@(posedge clk) disable iff (!rst_n)
    (imem.req || pending) |-> outstanding)
    else $error("request in flight but not marked outstanding");

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !imem.req) else $error("request during reset");

  a_redirect_drop: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |=> !window_valid) else $error("window still valid after redirect");

endmodule

bind ifu_fetch_buf ifu_assert i_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .imem         (imem),
  .imem_rvalid  (imem_rvalid),
  .outstanding  (outstanding),
  .redirect     (redirect),
  .window_valid (window_valid)
);

`default_nettype wire

// ==== hw/ifu.sv ====
/*
 * instruction fetch unit top: fetch buffer, predecoder, next pc and output stage
 */
`default_nettype none

module ifu #(
  parameter logic [31:1] reset_pc = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect,
  input  logic [31:1]         redirect_pc,
  output ifu_pkg::imem_req_t  imem,
  input  logic                imem_rvalid,
  input  logic [31:0]         imem_rdata,
  output ifu_pkg::fetch_out_t out,
  output logic                out_valid
);

  logic [31:1]          pc;
  ifu_pkg::fetch_word_u window;
  logic                 window_valid;  // advances pc and loads the output stage
  ifu_pkg::predecode_t  pd;

  ifu_fetch_buf i_fetch_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .redirect     (redirect),
    .imem         (imem),
    .imem_rvalid  (imem_rvalid),
    .imem_rdata   (imem_rdata),
    .window       (window),
    .window_valid (window_valid)
  );

  ifu_predecode i_predecode (
    .window (window),
    .pc     (pc),
    .pd     (pd)
  );

  ifu_next_pc #(
    .reset_pc (reset_pc)
  ) i_next_pc (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .window_valid (window_valid),
    .pd           (pd),
    .pc           (pc)
  );

  ifu_out_stage i_out_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_valid (window_valid),
    .redirect     (redirect),
    .window       (window),
    .pc           (pc),
    .pd           (pd),
    .out          (out),
    .out_valid    (out_valid)
  );

endmodule

`default_nettype wire

// ==== hw/ifu_out_stage.sv ====
/*
 * output register stage toward decode
 */
`default_nettype none

module ifu_out_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 window_valid,
  input  logic                 redirect,
  input  ifu_pkg::fetch_word_u window,
  input  logic [31:1]          pc,
  input  ifu_pkg::predecode_t  pd,
  output ifu_pkg::fetch_out_t  out,
  output logic                 out_valid
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_valid <= 1'b0;
    else out_valid <= window_valid && !redirect;  // the item is dropped when the back end redirects
  end

  always_ff @(posedge clk) begin
    if (window_valid) begin
      // upper parcel of a compressed instruction is not part of it, so it goes out as zero
      out.instr.parcel.hi <= pd.compressed ? 16'h0000 : window.parcel.hi;
      out.instr.parcel.lo <= window.parcel.lo;
      out.pc              <= pc;
      out.compressed      <= pd.compressed;
      out.br              <= pd.br;
      out.br_taken        <= 1'b0;  // no prediction in this front end
      out.illegal         <= pd.illegal;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ifu_next_pc.sv ====
/*
 * program counter register with redirect, jump and sequential selection
 */
`default_nettype none

module ifu_next_pc #(
  parameter logic [31:1] reset_pc = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect,
  input  logic [31:1]         redirect_pc,
  input  logic                window_valid,
  input  ifu_pkg::predecode_t pd,
  output logic [31:1]         pc
);

  logic [31:1] seq_pc;
  logic [31:1] pc_next;

  // pc counts halfwords so the step is 1 or 2
  assign seq_pc = pc + (pd.compressed ? 31'd1 : 31'd2);

  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;  // back end wins over anything fetched
    end else if (!window_valid) begin
      pc_next = pc;
    end else if (pd.jump) begin
      pc_next = pd.jump_target;
    end else begin
      pc_next = seq_pc;  // illegal instructions step on as well
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc <= reset_pc;
    else pc <= pc_next;
  end

endmodule

`default_nettype wire

// ==== hw/ifu_predecode.sv ====
/*
 * predecoder: classifies the fetch window and computes the direct jump target
 */
`default_nettype none

module ifu_predecode (
  input  ifu_pkg::fetch_word_u window,
  input  logic [31:1]          pc,
  output ifu_pkg::predecode_t  pd
);

  logic [15:0] c_instr;
  logic [2:0]  c_funct3;
  logic        compressed;
  logic        c_quad1;
  logic        c_jump;
  logic        c_branch;
  logic        jal;
  logic        branch;
  logic [31:1] cj_imm;
  logic [31:1] j_imm;
  logic [31:1] offset;

  assign c_instr  = window.parcel.lo;
  assign c_funct3 = c_instr[15:13];

  assign compressed = c_instr[1:0] != ifu_pkg::quad_rv32;
  assign c_quad1    = c_instr[1:0] == ifu_pkg::quad_c1;

  // C.J and C.JAL share the CJ immediate format
  assign c_jump   = c_quad1 && (c_funct3 == ifu_pkg::c_j || c_funct3 == ifu_pkg::c_jal);
  assign c_branch = c_quad1 && (c_funct3 == ifu_pkg::c_beqz || c_funct3 == ifu_pkg::c_bnez);

  assign jal    = !compressed && window.full.opcode == ifu_pkg::op_jal;
  assign branch = !compressed && window.full.opcode == ifu_pkg::op_branch;

  // offset[11|4|9:8|10|6|7|3:1|5] lives in bits 12:2 of the parcel
  assign cj_imm = {
    {21{c_instr[12]}},
    c_instr[8],
    c_instr[10:9],
    c_instr[6],
    c_instr[7],
    c_instr[2],
    c_instr[11],
    c_instr[5:3]
  };

  // imm[20|10:1|11|19:12] read back through the register fields
  assign j_imm = {
    {12{window.full.funct7[6]}},
    window.full.rs1,
    window.full.funct3,
    window.full.rs2[0],
    window.full.funct7[5:0],
    window.full.rs2[4:1]
  };

  assign offset = compressed ? cj_imm : j_imm;

  assign pd.compressed  = compressed;
  assign pd.jump        = c_jump || jal;
  assign pd.br          = c_branch || branch;
  assign pd.illegal     = c_instr == 16'h0000;  // the all-zero parcel is defined illegal
  assign pd.jump_target = pc + offset;          // halfword units, bit 0 of the offset is zero

endmodule

`default_nettype wire

// ==== hw/ifu_fetch_buf.sv ====
/*
 * fetch buffer: memory request sequencing, response capture with stale discard,
 * and assembly of the 32-bit window starting at a halfword pc
 */
`default_nettype none

module ifu_fetch_buf (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:1]          pc,
  input  logic                 redirect,
  output ifu_pkg::imem_req_t   imem,
  input  logic                 imem_rvalid,
  input  logic [31:0]          imem_rdata,
  output ifu_pkg::fetch_word_u window,
  output logic                 window_valid
);

  logic [31:0] slot_data [2];
  logic [31:2] slot_addr [2];
  logic [1:0]  slot_valid;
  logic        outstanding;
  logic        stale;    // the outstanding response belongs to a path left by redirect
  logic        req_q;
  logic [31:2] req_addr_q;

  logic [31:2] pc_word;
  logic [31:2] pc_word_next;
  logic        hit_lo;
  logic        hit_hi;
  logic [31:0] word_lo;
  logic [31:0] word_hi;
  logic [15:0] first_parcel;
  logic        need_hi;
  logic [31:2] fetch_addr;
  logic        issue;
  logic        capture;
  logic        victim;

  assign pc_word      = pc[31:2];
  assign pc_word_next = pc[31:2] + 30'd1;

  always_comb begin
    hit_lo  = 1'b0;
    hit_hi  = 1'b0;
    word_lo = slot_data[0];
    word_hi = slot_data[0];
    for (int i = 0; i < 2; i++) begin
      if (slot_valid[i] && slot_addr[i] == pc_word) begin
        hit_lo  = 1'b1;
        word_lo = slot_data[i];
      end
      if (slot_valid[i] && slot_addr[i] == pc_word_next) begin
        hit_hi  = 1'b1;
        word_hi = slot_data[i];
      end
    end
  end

  // the second word is only needed for a 32-bit instruction in the upper half
  assign first_parcel = pc[1] ? word_lo[31:16] : word_lo[15:0];
  assign need_hi      = pc[1] && (first_parcel[1:0] == ifu_pkg::quad_rv32);
  assign window_valid = hit_lo && (!need_hi || hit_hi);
  assign window       = pc[1] ? {word_hi[15:0], word_lo[31:16]} : word_lo;

  assign fetch_addr = hit_lo ? pc_word_next : pc_word;
  assign issue      = !window_valid && !outstanding && !imem_rvalid && !redirect;
  assign capture    = imem_rvalid && !stale && !redirect;

  // keep the slot that the current window still reads
  assign victim = slot_valid[0] && (slot_addr[0] == pc_word || slot_addr[0] == pc_word_next);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
    end else begin
      req_q <= issue;  // one cycle strobe
      if (imem_rvalid) begin
        outstanding <= 1'b0;
        stale       <= 1'b0;
      end else if (outstanding && redirect) begin
        stale <= 1'b1;
      end else if (issue) begin
        outstanding <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) req_addr_q <= fetch_addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) slot_valid <= '0;
    else if (redirect) slot_valid <= '0;
    else if (capture) slot_valid[victim] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      slot_data[victim] <= imem_rdata;
      slot_addr[victim] <= req_addr_q;  // address of the single outstanding request
    end
  end

  assign imem.req  = req_q;
  assign imem.addr = req_addr_q;

endmodule

`default_nettype wire

// ==== hw/ifu_pkg.sv ====
/*
 * shared fetch unit types: instruction word union, fetch output and predecode
 * structs, instruction memory request struct and opcode constants
 */
`default_nettype none

package ifu_pkg;

  // field split of a 32-bit instruction
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } full_instr_t;

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;  // a compressed instruction always sits in the low parcel
  } parcel_pair_t;

  // the same 32-bit window, read as one instruction or as two parcels
  typedef union packed {
    full_instr_t  full;
    parcel_pair_t parcel;
  } fetch_word_u;

  // one instruction handed to decode
  typedef struct packed {
    fetch_word_u instr;
    logic [31:1] pc;
    logic        compressed;
    logic        br;
    logic        br_taken;
    logic        illegal;
  } fetch_out_t;

  typedef struct packed {
    logic        compressed;
    logic        jump;         // direct jump whose target is known at fetch
    logic        br;
    logic        illegal;
    logic [31:1] jump_target;
  } predecode_t;

  typedef struct packed {
    logic        req;
    logic [31:2] addr;  // word address
  } imem_req_t;

  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // funct3 of the quadrant 1 control transfers
  localparam logic [2:0] c_j    = 3'b101;
  localparam logic [2:0] c_jal  = 3'b001;
  localparam logic [2:0] c_beqz = 3'b110;
  localparam logic [2:0] c_bnez = 3'b111;

  localparam logic [1:0] quad_c1   = 2'b01;
  localparam logic [1:0] quad_rv32 = 2'b11;  // low bits of every 32-bit instruction

endpackage

`default_nettype wire
